// File: project.f
rtl/atom_pkg.sv
rtl/cpu_bus_if.sv
rtl/cpu_clock_enables.sv
rtl/atom_pia.sv
rtl/atom_bus_decode.sv
rtl/atom_glue.sv
bench/tb_clock.sv
bench/tb_atom_glue.sv

// File: run.sh
#!/bin/sh
# Build and run the Atom glue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_atom_glue -f project.f -o tb_atom_glue

./obj_dir/tb_atom_glue > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
   exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
   exit 1
fi

// File: bench/tb_atom_glue.sv
/*
 * Testbench for the Atom bus glue. Plays the CPU on the plain bus ports,
 * models RAM contents, and checks enables, PIA, banking, strobes and lock.
 */
`timescale 1ns/10ps

module tb_atom_glue;
   import atom_pkg::*;

   logic        clk25;
   logic        reset;
   turbo_t      turbo;
   addr_t       cpu_addr;
   data_t       cpu_wdata;
   logic        cpu_rnw;
   data_t       cpu_din;
   logic        cpu_clken;
   data_t       port_b;
   logic        fs_n;
   logic        rept_n;
   logic        cas_in;
   data_t       port_a;
   logic [3:0]  port_c_low;
   logic        sound;
   logic        cas_out;
   ram_addr_t   ram_addr;
   data_t       ram_wdata;
   data_t       ram_rdata;
   logic        ram_oe_n;
   logic        ram_we_n;
   logic        lock;

   // Reference model of the DUT registers
   data_t       m_pa;
   data_t       m_latch;
   logic [3:0]  m_pcl;
   int unsigned clken_total = 0;
   int unsigned we_falls = 0;
   logic        monitor_en = 1'b0;

   // Bookkeeping
   logic [31:0] lcg_state;
   int          n_checks = 0;
   int          n_errors = 0;
   int          n_tests = 0;
   int          test_err0 = 0;

   // Values captured mid-access
   data_t       cap_din;
   data_t       cap_exp_din;
   data_t       cap_wdata;
   ram_addr_t   cap_ram_addr;
   ram_addr_t   cap_exp_ra;
   logic        cap_oe_n;

   tb_clock u_clock (
      .clk25 (clk25)
   );

   atom_glue u_atom_glue (.*);

   // External RAM whose contents follow the address
   assign ram_rdata = ram_fill(ram_addr);

   // ============================================================
   // Reference model
   // ============================================================

   function automatic data_t ram_fill(ram_addr_t a);
      return a[7:0] ^ {a[14:8], a[15]} ^ {6'b0, a[17:16]};
   endfunction

   function automatic logic [15:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[31:16];
   endfunction

   // A000-AFFF maps to page latch[2:0] at 10000
   function automatic ram_addr_t ref_ram_addr(addr_t a);
      if (a[15:12] == bank_window)
         return {3'b010, m_latch[2:0], a[11:0]};
      return {2'b00, a};
   endfunction

   // Tone flips once per 208 enables since reset
   function automatic logic ref_tone();
      return ((clken_total / cas_toggle_count) % 2) == 1;
   endfunction

   function automatic logic ref_cas_out();
      return m_pcl[0] && !(m_pcl[1] && !ref_tone());
   endfunction

   function automatic data_t ref_cpu_din(addr_t a);
      data_t r;
      if (a[15:4] == pia_page)
      begin
         if (a[1:0] == 2'd0)
            r = m_pa;
         else if (a[1:0] == 2'd1)
            r = port_b;
         else if (a[1:0] == 2'd2)
            r = {fs_n, rept_n, cas_in, ref_tone(), m_pcl};
         else
            r = 8'h00;
      end
      else if (a[15:4] == empty_page)
         r = 8'h00;
      else if (a == bank_latch_addr)
         r = m_latch;
      else
         r = ram_fill(ref_ram_addr(a));
      return r;
   endfunction

   task automatic model_write(input addr_t a, input data_t d);
      if (a == bank_latch_addr)
         m_latch = d;
      if (a[15:4] == pia_page)
      begin
         if (a[1:0] == 2'd0)
            m_pa = d;
         else if (a[1:0] == 2'd2)
            m_pcl = d[3:0];
         // Bit set/reset only when bit 7 is clear
         else if (a[1:0] == 2'd3 && !d[7])
            m_pcl[d[2:1]] = d[0];
      end
   endtask

   // Enables counted as the DUT sees them
   always @(posedge clk25 or posedge reset)
   begin
      if (reset)
         clken_total <= 0;
      else if (cpu_clken)
         clken_total <= clken_total + 1;
   end

   always @(negedge ram_we_n)
      we_falls = we_falls + 1;

   // ============================================================
   // Compare tasks
   // ============================================================

   task automatic check_data(input string name, input data_t got, input data_t exp);
      n_checks++;
      if (got !== exp)
      begin
         n_errors++;
         $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_ram_addr(input string name, input ram_addr_t got,
                                 input ram_addr_t exp);
      n_checks++;
      if (got !== exp)
      begin
         n_errors++;
         $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      n_checks++;
      if (got !== exp)
      begin
         n_errors++;
         $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      n_checks++;
      if (got != exp)
      begin
         n_errors++;
         $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   // Held port C read checked on every falling edge
   always @(negedge clk25)
   begin
      if (monitor_en)
      begin
         check_data("cpu_din", cpu_din, ref_cpu_din({pia_page, 4'h2}));
         check_bit("cas_out", cas_out, ref_cas_out());
         check_bit("sound", sound, m_pcl[2]);
      end
   end

   // ============================================================
   // Run control and bus driver
   // ============================================================

   task automatic report_and_finish();
      $display("Tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
      if (n_errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   endtask

   task automatic end_test(input string name);
      n_tests++;
      $display("Test %0d %s finished, %0d errors", n_tests, name, n_errors - test_err0);
      test_err0 = n_errors;
   endtask

   // Returns on a falling edge with cpu_clken high
   task automatic wait_clken();
      int n = 0;
      do
      begin
         @(negedge clk25);
         n++;
      end
      while (!cpu_clken && n < 64);
      if (!cpu_clken)
      begin
         $display("Timeout at %0t, no cpu_clken pulse within 64 cycles", $time);
         n_errors++;
         report_and_finish();
      end
   endtask

   // One access before the bus falls back to an idle read of 0000
   task automatic bus_access(input addr_t a, input data_t d, input logic rnw);
      wait_clken();
      cpu_addr  = a;
      cpu_wdata = d;
      cpu_rnw   = rnw;
      // Registered bus now holds the access
      wait_clken();
      cap_din      = cpu_din;
      cap_ram_addr = ram_addr;
      cap_wdata    = ram_wdata;
      cap_oe_n     = ram_oe_n;
      cap_exp_din  = ref_cpu_din(a);
      cap_exp_ra   = ref_ram_addr(a);
      cpu_addr     = 16'h0000;
      cpu_rnw      = 1'b1;
      // Write has landed by the next pulse
      wait_clken();
      if (!rnw)
         model_write(a, d);
   endtask

   task automatic bus_write(input addr_t a, input data_t d);
      bus_access(a, d, 1'b0);
   endtask

   task automatic bus_read(input addr_t a);
      bus_access(a, 8'h00, 1'b1);
   endtask

   task automatic apply_reset();
      @(negedge clk25);
      reset = 1'b1;
      repeat (4) @(negedge clk25);
      reset   = 1'b0;
      m_pa    = '0;
      m_pcl   = '0;
      m_latch = '0;
   endtask

   // ============================================================
   // Tests
   // ============================================================

   initial
   begin
      int          i;
      int          count;
      int unsigned n0;
      logic        prev;
      data_t       d;
      addr_t       a;

      lcg_state = 32;
      reset     = 1'b1;
      turbo     = speed_1mhz;
      cpu_addr  = '0;
      cpu_wdata = '0;
      cpu_rnw   = 1'b1;
      port_b    = '0;
      fs_n      = 1'b1;
      rept_n    = 1'b1;
      cas_in    = 1'b0;
      apply_reset();

      // Enable rate per turbo speed over ten divider periods
      for (i = 0; i < 4; i++)
      begin
         @(negedge clk25);
         turbo = turbo_t'(i);
         count = 0;
         prev  = 1'b0;
         repeat (250)
         begin
            @(negedge clk25);
            if (cpu_clken && prev && i != 3)
            begin
               $display("Back-to-back cpu_clken pulses at turbo setting %0d", i);
               n_errors++;
            end
            prev = cpu_clken;
            if (cpu_clken)
               count++;
         end
         check_count("cpu_clken pulses", count, 10 << i);
      end
      end_test("clock enables");

      // PIA registers and inputs
      repeat (6)
      begin
         bus_write({pia_page, 4'h0}, data_t'(lcg_next()));
         check_data("port_a", port_a, m_pa);
         bus_read({pia_page, 4'h0});
         check_data("cpu_din", cap_din, cap_exp_din);
         bus_write({pia_page, 4'h2}, data_t'(lcg_next()));
         check_data("port_c_low", {4'h0, port_c_low}, {4'h0, m_pcl});
         bus_read({pia_page, 4'h2});
         check_data("cpu_din", cap_din, cap_exp_din);
      end
      // Mode words mixed in with bit set/reset
      repeat (12)
      begin
         bus_write({pia_page, 4'h3}, data_t'(lcg_next()));
         check_data("port_c_low", {4'h0, port_c_low}, {4'h0, m_pcl});
      end
      repeat (4)
      begin
         port_b = data_t'(lcg_next());
         {fs_n, rept_n, cas_in} = 3'(lcg_next() >> 5);
         bus_read({pia_page, 4'h1});
         check_data("cpu_din", cap_din, cap_exp_din);
         bus_read({pia_page, 4'h2});
         check_data("cpu_din", cap_din, cap_exp_din);
         bus_read({pia_page, 4'h3});
         check_data("cpu_din", cap_din, cap_exp_din);
      end
      // Lock flag set so reset has something to clear
      bus_write(lock_flag_addr, data_t'(1 << lock_bit));
      apply_reset();
      check_data("port_a", port_a, 8'h00);
      check_data("port_c_low", {4'h0, port_c_low}, 8'h00);
      check_bit("lock", lock, 1'b0);
      end_test("pia");

      // Bank latch and the RAM address map
      repeat (6)
      begin
         bus_write(bank_latch_addr, data_t'(lcg_next()));
         bus_read(bank_latch_addr);
         check_data("cpu_din", cap_din, cap_exp_din);
         repeat (6)
         begin
            a = addr_t'(lcg_next());
            if (a[0])
               a[15:12] = bank_window;
            bus_read(a);
            check_ram_addr("ram_addr", cap_ram_addr, cap_exp_ra);
            check_data("cpu_din", cap_din, cap_exp_din);
         end
         bus_read({empty_page, 4'(lcg_next())});
         check_data("cpu_din", cap_din, 8'h00);
      end
      end_test("banking");

      // Write strobe outside and inside the ROM region
      repeat (8)
      begin
         a = addr_t'(lcg_next());
         if (a[15:14] == rom_region)
            a[15] = 1'b0;
         d  = data_t'(lcg_next());
         n0 = we_falls;
         bus_write(a, d);
         check_count("ram_we_n pulses", int'(we_falls - n0), 1);
         check_data("ram_wdata", cap_wdata, d);
         check_bit("ram_oe_n", cap_oe_n, 1'b1);
         a[15:14] = rom_region;
         n0 = we_falls;
         bus_write(a, d);
         check_count("ram_we_n pulses", int'(we_falls - n0), 0);
         bus_read(a);
         check_bit("ram_oe_n", cap_oe_n, 1'b0);
      end
      end_test("ram strobes");

      // Sound and cassette output followed by the tone at 8 MHz
      for (i = 0; i < 16; i++)
      begin
         bus_write({pia_page, 4'h2}, data_t'(i));
         check_bit("sound", sound, m_pcl[2]);
         check_bit("cas_out", cas_out, ref_cas_out());
      end
      bus_write({pia_page, 4'h2}, 8'h03);
      wait_clken();
      cpu_addr = {pia_page, 4'h2};
      cpu_rnw  = 1'b1;
      wait_clken();
      monitor_en = 1'b1;
      repeat (3 * cas_toggle_count) wait_clken();
      monitor_en = 1'b0;
      end_test("cassette tone");

      // Lock flag snoop
      repeat (6)
      begin
         d = data_t'(lcg_next());
         bus_write(lock_flag_addr, d);
         check_bit("lock", lock, d[lock_bit]);
         a = addr_t'(lcg_next());
         if (a == lock_flag_addr)
            a = a + 16'd1;
         bus_write(a, data_t'(lcg_next()));
         check_bit("lock", lock, d[lock_bit]);
      end
      end_test("lock flag");

      report_and_finish();
   end

endmodule

// File: bench/tb_clock.sv
/*
 * Testbench clock source, 100 ns period, starts low.
 */
`timescale 1ns/10ps

module tb_clock (
   output logic clk25
);

   // Half period in ns
   initial
   begin
      clk25 = 1'b0;
      forever
         #50 clk25 = !clk25;
   end

endmodule

// File: rtl/atom_glue.sv
/*
 * Top level of the Atom bus glue. The CPU bus arrives on plain ports,
 * is registered on cpu_clken and shared with the decoder and the PIA.
 */
`timescale 1ns/10ps

module atom_glue (
   input  logic                clk25,
   input  logic                reset,
   input  atom_pkg::turbo_t    turbo,
   input  atom_pkg::addr_t     cpu_addr,
   input  atom_pkg::data_t     cpu_wdata,
   input  logic                cpu_rnw,
   output atom_pkg::data_t     cpu_din,
   output logic                cpu_clken,
   input  atom_pkg::data_t     port_b,
   input  logic                fs_n,
   input  logic                rept_n,
   input  logic                cas_in,
   output atom_pkg::data_t     port_a,
   output logic [3:0]          port_c_low,
   output logic                sound,
   output logic                cas_out,
   output atom_pkg::ram_addr_t ram_addr,
   output atom_pkg::data_t     ram_wdata,
   input  atom_pkg::data_t     ram_rdata,
   output logic                ram_oe_n,
   output logic                ram_we_n,
   output logic                lock
);
   import atom_pkg::*;

   addr_t addr_q;
   data_t wdata_q;
   logic  rnw_q;
   logic  wegate_n;
   logic  pia_sel;
   data_t pia_rdata;

   cpu_bus_if bus ();

   // ============================================================
   // CPU output registers
   // ============================================================

   // Idle as a read so nothing is written before the first access
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         rnw_q <= 1'b1;
      else if (cpu_clken)
         rnw_q <= cpu_rnw;
   end

   always_ff @(posedge clk25)
   begin
      if (cpu_clken)
      begin
         addr_q  <= cpu_addr;
         wdata_q <= cpu_wdata;
      end
   end

   assign bus.addr  = addr_q;
   assign bus.wdata = wdata_q;
   assign bus.rnw   = rnw_q;
   assign bus.clken = cpu_clken;

   cpu_clock_enables u_cpu_clock_enables (
      .clk25     (clk25),
      .reset     (reset),
      .turbo     (turbo),
      .cpu_clken (cpu_clken),
      .wegate_n  (wegate_n)
   );

   atom_bus_decode u_atom_bus_decode (
      .clk25     (clk25),
      .reset     (reset),
      .bus       (bus.target),
      .wegate_n  (wegate_n),
      .pia_sel   (pia_sel),
      .pia_rdata (pia_rdata),
      .ram_rdata (ram_rdata),
      .ram_addr  (ram_addr),
      .ram_wdata (ram_wdata),
      .ram_oe_n  (ram_oe_n),
      .ram_we_n  (ram_we_n),
      .cpu_din   (cpu_din),
      .lock      (lock)
   );

   atom_pia u_atom_pia (
      .clk25      (clk25),
      .reset      (reset),
      .bus        (bus.target),
      .pia_sel    (pia_sel),
      .pia_rdata  (pia_rdata),
      .port_b     (port_b),
      .fs_n       (fs_n),
      .rept_n     (rept_n),
      .cas_in     (cas_in),
      .port_a     (port_a),
      .port_c_low (port_c_low),
      .sound      (sound),
      .cas_out    (cas_out)
   );

endmodule

// File: rtl/atom_bus_decode.sv
/*
 * Atom address decoder: chip selects, bank latch at BFFF, external
 * RAM address and strobes, lock flag snoop and the CPU read mux.
 */
`timescale 1ns/10ps

module atom_bus_decode (
   input  logic                clk25,
   input  logic                reset,
   cpu_bus_if.target           bus,
   input  logic                wegate_n,
   output logic                pia_sel,
   input  atom_pkg::data_t     pia_rdata,
   input  atom_pkg::data_t     ram_rdata,
   output atom_pkg::ram_addr_t ram_addr,
   output atom_pkg::data_t     ram_wdata,
   output logic                ram_oe_n,
   output logic                ram_we_n,
   output atom_pkg::data_t     cpu_din,
   output logic                lock
);
   import atom_pkg::*;

   logic  empty_sel;
   logic  bank_sel;
   logic  latch_sel;
   logic  rom_sel;
   logic  bus_wr;
   data_t bank_latch;

   // ============================================================
   // Chip selects
   // ============================================================

   // B000-B00F 8255
   assign pia_sel   = (bus.addr[15:4] == pia_page);
   // B400-B40F reads zero
   assign empty_sel = (bus.addr[15:4] == empty_page);
   // A000-AFFF banked window
   assign bank_sel  = (bus.addr[15:12] == bank_window);
   assign latch_sel = (bus.addr == bank_latch_addr);
   // C000-FFFF ROM images, write protected
   assign rom_sel   = (bus.addr[15:14] == rom_region);

   assign bus_wr = bus.clken && !bus.rnw;

   // ============================================================
   // Bank latch and lock snoop
   // ============================================================

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         bank_latch <= '0;
      else if (bus_wr && latch_sel)
         bank_latch <= bus.wdata;
   end

   // Lock flag lives in zero page, copy it as it is written
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         lock <= 1'b0;
      else if (bus_wr && (bus.addr == lock_flag_addr))
         lock <= bus.wdata[lock_bit];
   end

   // ============================================================
   // External RAM
   // ============================================================

   // Only three latch bits reach the RAM, eight pages of 4 KB
   assign ram_addr = bank_sel ? {bank_ram_prefix, bank_latch[2:0], bus.addr[11:0]}
                              : {2'b00, bus.addr};
   assign ram_wdata = bus.wdata;
   assign ram_oe_n  = !bus.rnw;
   // Gate from the enable generator sets the pulse position
   assign ram_we_n  = bus.rnw || wegate_n || rom_sel;

   // ============================================================
   // Read mux
   // ============================================================

   always_comb
   begin
      if (pia_sel)
         cpu_din = pia_rdata;
      else if (empty_sel)
         cpu_din = '0;
      else if (latch_sel)
         cpu_din = bank_latch;
      else
         cpu_din = ram_rdata;
   end

   // RAM must never see both strobes, checked on both clock edges
   a_strobe_excl: assert property (@(clk25) disable iff (reset)
      !ram_we_n |-> ram_oe_n);

endmodule

// File: rtl/atom_pia.sv
/*
 * Crude 8255 model at B000 with fixed port directions, plus the
 * cassette tone divider and the sound and cassette output logic.
 */
`timescale 1ns/10ps

module atom_pia (
   input  logic            clk25,
   input  logic            reset,
   cpu_bus_if.target       bus,
   input  logic            pia_sel,
   output atom_pkg::data_t pia_rdata,
   input  atom_pkg::data_t port_b,
   input  logic            fs_n,
   input  logic            rept_n,
   input  logic            cas_in,
   output atom_pkg::data_t port_a,
   output logic [3:0]      port_c_low,
   output logic            sound,
   output logic            cas_out
);
   import atom_pkg::*;

   logic                     wr_en;
   data_t                    port_c;
   logic [cas_div_width-1:0] cas_div;
   logic                     cas_tone;

   // Qualified write strobe, address already decoded upstream
   assign wr_en = pia_sel && bus.clken && !bus.rnw;

   // ============================================================
   // Registers
   // ============================================================

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         port_a     <= '0;
         port_c_low <= '0;
      end
      else if (wr_en)
      begin
         case (pia_reg_e'(bus.addr[1:0]))
            atom_pkg::port_a: port_a <= bus.wdata;
            atom_pkg::port_c: port_c_low <= bus.wdata[3:0];
            atom_pkg::control:
            begin
               // Bit set/reset form only, mode words ignored
               if (!bus.wdata[7])
                  port_c_low[bus.wdata[2:1]] <= bus.wdata[0];
            end
            default: ;
         endcase
      end
   end

   // Upper nibble of port C is all inputs
   assign port_c = {fs_n, rept_n, cas_in, cas_tone, port_c_low};

   always_comb
   begin
      case (pia_reg_e'(bus.addr[1:0]))
         atom_pkg::port_a: pia_rdata = port_a;
         atom_pkg::port_b: pia_rdata = port_b;
         atom_pkg::port_c: pia_rdata = port_c;
         default:          pia_rdata = '0;
      endcase
   end

   // ============================================================
   // Cassette tone
   // ============================================================

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         cas_div  <= '0;
         cas_tone <= 1'b0;
      end
      else if (bus.clken)
      begin
         if (cas_div == cas_div_width'(cas_toggle_count - 1))
         begin
            cas_div  <= '0;
            cas_tone <= !cas_tone;
         end
         else
            cas_div <= cas_div + 1'b1;
      end
   end

   assign sound = port_c_low[2];
   // Bit 1 gates the tone onto the cassette line, bit 0 enables it
   assign cas_out = port_c_low[0] && !(port_c_low[1] && !cas_tone);

   // Select must come from a known address
   a_sel_known: assert property (@(posedge clk25) disable iff (reset)
      $rose(pia_sel) |-> !$isunknown(bus.addr));

endmodule

// File: rtl/cpu_clock_enables.sv
/*
 * CPU clock enable at 1, 2, 4 or 8 MHz from the 25 MHz clock,
 * plus a write gate retimed on the falling edge.
 */
`timescale 1ns/10ps

module cpu_clock_enables (
   input  logic             clk25,
   input  logic             reset,
   input  atom_pkg::turbo_t turbo,
   output logic             cpu_clken,
   output logic             wegate_n
);
   import atom_pkg::*;

   logic [clkdiv_width-1:0] clkdiv;
   logic                    clken_next;
   logic                    cpu_clken_d;

   // ============================================================
   // 25-state divider
   // ============================================================

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         clkdiv <= '0;
      else if (clkdiv == clkdiv_width'(clkdiv_period - 1))
         clkdiv <= '0;
      else
         clkdiv <= clkdiv + 1'b1;
   end

   // Pulses only in the first 16 states, spread evenly
   always_comb
   begin
      case (turbo)
         speed_1mhz: clken_next = (clkdiv[3:0] == 4'd0) && !clkdiv[4];
         speed_2mhz: clken_next = (clkdiv[2:0] == 3'd0) && !clkdiv[4];
         speed_4mhz: clken_next = (clkdiv[1:0] == 2'd0) && !clkdiv[4];
         default:    clken_next = !clkdiv[0] && !clkdiv[4];
      endcase
   end

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         cpu_clken   <= 1'b0;
         cpu_clken_d <= 1'b0;
      end
      else
      begin
         cpu_clken   <= clken_next;
         // One cycle behind, inside the new access
         cpu_clken_d <= cpu_clken;
      end
   end

   // ============================================================
   // Write gate
   // ============================================================

   // Falling edge centres the gate in a two-cycle access at 8 MHz
   always_ff @(negedge clk25 or posedge reset)
   begin
      if (reset)
         wegate_n <= 1'b1;
      else
         wegate_n <= !cpu_clken_d;
   end

   // Divider must wrap at the period
   a_clkdiv_range: assert property (@(posedge clk25) disable iff (reset)
      clkdiv < clkdiv_width'(clkdiv_period));

endmodule

// File: rtl/cpu_bus_if.sv
/*
 * Registered CPU bus shared by the decoder and the PIA.
 * Writes land on a clk25 edge with clken high and rnw low.
 */
`timescale 1ns/10ps

interface cpu_bus_if;
   import atom_pkg::*;

   // Registered address and write data from the top level
   addr_t addr;
   data_t wdata;
   // High for reads, low for writes
   logic  rnw;
   // One-cycle CPU clock enable
   logic  clken;

   modport master (output addr, output wdata, output rnw, output clken);

   // Peripherals only look at the bus
   modport target (input addr, input wdata, input rnw, input clken);

endinterface

// File: rtl/atom_pkg.sv
/*
 * Shared types, memory map and divider constants for the Atom bus glue.
 * Modules import this package inside their bodies.
 */
package atom_pkg;

   // ============================================================
   // Bus types
   // ============================================================

   typedef logic [15:0] addr_t;
   typedef logic [7:0]  data_t;
   typedef logic [17:0] ram_addr_t;

   // Turbo speed, one CPU enable pattern each
   typedef enum logic [1:0] {
      speed_1mhz,
      speed_2mhz,
      speed_4mhz,
      speed_8mhz
   } turbo_t;

   // 8255 register select, address bits 1..0
   typedef enum logic [1:0] {
      port_a,
      port_b,
      port_c,
      control
   } pia_reg_e;

   // ============================================================
   // Dividers
   // ============================================================

   localparam int clkdiv_period    = 25;
   localparam int clkdiv_width     = $clog2(clkdiv_period);
   // 4 MHz / 16 / 13 / 8 on the real machine, same rate here
   localparam int cas_toggle_count = 208;
   localparam int cas_div_width    = $clog2(cas_toggle_count);

   // ============================================================
   // Memory map
   // ============================================================

   localparam logic [11:0] pia_page        = 12'hb00;
   localparam logic [11:0] empty_page      = 12'hb40;
   localparam addr_t       bank_latch_addr = 16'hbfff;
   localparam addr_t       lock_flag_addr  = 16'h00e7;
   localparam int          lock_bit        = 5;
   localparam logic [3:0]  bank_window     = 4'ha;
   localparam logic [1:0]  rom_region      = 2'b11;
   // Banked pages sit at 10000-17FFF of external RAM
   localparam logic [2:0]  bank_ram_prefix = 3'b010;

endpackage
